/* Makefile */
# Verilator simulation of the instruction cache lookup side

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_icache -f compile.f -o Vtb_icache
	out="$$(./obj_dir/Vtb_icache 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

/* common/icache_pkg.sv */
/*
 * Instruction cache types
 * Field types and positions used to split a fetch address
 */

`include "icache_settings.svh"

package icache_pkg;

	// =========================================================================
	// Field widths
	// =========================================================================

	// The index sits right above the byte offset
	localparam int INDEX_W = $clog2(`ICACHE_LINES);
	// The stored tag keeps every bit above the offset, index bits included
	localparam int TAG_W = `ICACHE_AWID - `ICACHE_OFFSET_W;
	localparam int WAY_W = $clog2(`ICACHE_WAYS);

	// Lowest address bit of each field
	localparam int INDEX_LSB = `ICACHE_OFFSET_W;
	localparam int TAG_LSB = `ICACHE_OFFSET_W;

	// =========================================================================
	// Types
	// =========================================================================

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WAY_W-1:0] way_t;
	typedef logic [`ICACHE_DATA_W-1:0] line_t;
	// One bit per way, bit n belongs to way n
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

endpackage

/* common/icache_settings.svh */
/*
 * Instruction cache geometry
 * Set count, associativity, address width and line layout for the lookup side
 */

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Number of sets in each way
`define ICACHE_LINES 128
// Ways per set
`define ICACHE_WAYS 4
// Width of the fetch address
`define ICACHE_AWID 32
// Byte offset bits inside one line
`define ICACHE_OFFSET_W 6
// Width of one cache line payload
`define ICACHE_DATA_W 128

`endif

/* compile.f */
+incdir+common
common/icache_pkg.sv
icache/icache_way_array.sv
icache/icache_hit_detect.sv
icache/icache_fill_ctrl.sv
icache/icache_top.sv
tests/tb_icache.sv

/* icache/icache_fill_ctrl.sv */
/*
 * Cache fill controller
 * Owns the valid bits and per set round-robin pointers, turns a fill
 * strobe into array writes and reports the tag of a displaced line
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_fill_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    fill,
	input  logic [`ICACHE_AWID-1:0] fill_addr,
	input  logic                    inv,
	input  logic                    lookup,
	input  logic [`ICACHE_AWID-1:0] lookup_ip,
	input  icache_pkg::tag_t        old_tags [`ICACHE_WAYS],
	output icache_pkg::index_t      rd_index,
	output icache_pkg::way_mask_t   valid,
	output icache_pkg::way_mask_t   wr_mask,
	output icache_pkg::index_t      wr_index,
	output icache_pkg::tag_t        wr_tag,
	output logic                    evict_valid,
	output icache_pkg::tag_t        evict_tag
);

	import icache_pkg::*;

	// Valid bits per set, one bit per way
	way_mask_t valid_q [`ICACHE_LINES];
	// Next victim way per set
	way_t rr_q [`ICACHE_LINES];

	index_t fill_index;
	index_t lookup_index;
	way_t victim;
	// A fill that is not cancelled by a same cycle invalidate
	logic fill_go;

	// =========================================================================
	// Fill decode
	// =========================================================================

	assign fill_index = fill_addr[INDEX_LSB +: INDEX_W];
	assign lookup_index = lookup_ip[INDEX_LSB +: INDEX_W];
	assign fill_go = fill && !inv;
	assign victim = rr_q[fill_index];

	// The tag array read port serves the old tag during a fill
	// and the lookup set otherwise
	assign rd_index = fill ? fill_index : lookup_index;
	assign valid = valid_q[rd_index];

	// Array writes happen at the edge where fill is high
	assign wr_mask = fill_go ? (way_mask_t'(1) << victim) : '0;
	assign wr_index = fill_index;
	assign wr_tag = fill_addr[`ICACHE_AWID-1:TAG_LSB];

	// =========================================================================
	// Valid bits, pointers and eviction report
	// =========================================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < `ICACHE_LINES; s++)
			begin
				valid_q[s] <= '0;
				rr_q[s] <= '0;
			end
			evict_valid <= 1'b0;
		end
		else
		begin
			// Invalidate clears every set but keeps the pointers
			if (inv)
			begin
				for (int s = 0; s < `ICACHE_LINES; s++)
					valid_q[s] <= '0;
			end
			else if (fill)
			begin
				valid_q[fill_index][victim] <= 1'b1;
				rr_q[fill_index] <= victim + way_t'(1);
			end
			// Only a valid victim is worth reporting
			evict_valid <= fill_go && valid_q[fill_index][victim];
		end
	end

	// The old tag is read through rd_index in the fill cycle
	always_ff @(posedge clk)
	begin
		if (fill_go)
			evict_tag <= old_tags[victim];
	end

	// The tag read port is shared, so the hit detector and a fill cannot meet
	a_no_fill_lookup: assert property (
		@(posedge clk) disable iff (!arst_n) !(fill && lookup)
	);

endmodule

/* icache/icache_hit_detect.sv */
/*
 * Cache hit detector
 * Compares the fetch tag with all ways of the indexed set and
 * registers hit, hit way and the hit line one cycle after the lookup
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_hit_detect (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    lookup,
	input  logic [`ICACHE_AWID-1:0] ip,
	input  icache_pkg::tag_t        tags [`ICACHE_WAYS],
	input  icache_pkg::line_t       lines [`ICACHE_WAYS],
	input  icache_pkg::way_mask_t   valid,
	output logic                    hit_valid,
	output logic                    hit,
	output icache_pkg::way_t        hit_way,
	output icache_pkg::line_t       hit_data
);

	import icache_pkg::*;

	// Tag field of the fetch address
	tag_t ip_tag;
	// Per way compare result, already qualified by the valid bit
	way_mask_t match;
	// Encoded matching way and the line it holds
	way_t match_way;

	assign ip_tag = ip[`ICACHE_AWID-1:TAG_LSB];

	// =========================================================================
	// Compare
	// =========================================================================

	always_comb
	begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
			match[w] = (tags[w] == ip_tag) && valid[w];
	end

	// Encode the matching way
	// With at most one match the loop order does not matter
	always_comb
	begin
		match_way = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++)
		begin
			if (match[w])
				match_way = way_t'(w);
		end
	end

	// =========================================================================
	// Result registers
	// =========================================================================

	// Strobe and hit flag are control state
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hit_valid <= 1'b0;
			hit <= 1'b0;
			hit_way <= '0;
		end
		else
		begin
			hit_valid <= lookup;
			hit <= lookup && (|match);
			// A miss leaves the last hit way in place
			if (lookup && (|match))
				hit_way <= match_way;
		end
	end

	// The line follows the same rule as the way
	always_ff @(posedge clk)
	begin
		if (lookup && (|match))
			hit_data <= lines[match_way];
	end

	// A set never holds the same valid tag twice
	// This depends on the tag array contents and the fill controller valid bits
	a_single_match: assert property (
		@(posedge clk) disable iff (!arst_n) lookup |-> $onehot0(match)
	);

endmodule

/* icache/icache_top.sv */
/*
 * Instruction cache lookup top
 * Joins the tag and data arrays, the hit detector and the fill controller
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    lookup,
	input  logic [`ICACHE_AWID-1:0] ip,
	input  logic                    fill,
	input  logic [`ICACHE_AWID-1:0] fill_addr,
	input  icache_pkg::line_t       fill_data,
	input  logic                    inv,
	output logic                    hit_valid,
	output logic                    hit,
	output icache_pkg::way_t        hit_way,
	output icache_pkg::line_t       hit_data,
	output logic                    evict_valid,
	output icache_pkg::tag_t        evict_tag
);

	import icache_pkg::*;

	// Lookup side of the arrays
	index_t ip_index;
	index_t tag_rd_index;
	tag_t set_tags [`ICACHE_WAYS];
	line_t set_lines [`ICACHE_WAYS];
	way_mask_t set_valid;

	// Fill side of the arrays
	way_mask_t wr_mask;
	index_t wr_index;
	tag_t wr_tag;

	assign ip_index = ip[INDEX_LSB +: INDEX_W];

	// =========================================================================
	// Storage
	// =========================================================================

	// Tag reads follow the fill controller so evictions see the old tag
	icache_way_array #(.entry_t(tag_t)) u_tag_array (
		.clk        (clk),
		.rd_index   (tag_rd_index),
		.wr_mask    (wr_mask),
		.wr_index   (wr_index),
		.wr_entry   (wr_tag),
		.rd_entries (set_tags)
	);

	// Line data is only read for lookups
	icache_way_array #(.entry_t(line_t)) u_data_array (
		.clk        (clk),
		.rd_index   (ip_index),
		.wr_mask    (wr_mask),
		.wr_index   (wr_index),
		.wr_entry   (fill_data),
		.rd_entries (set_lines)
	);

	// =========================================================================
	// Lookup and update
	// =========================================================================

	icache_hit_detect u_hit_detect (
		.clk       (clk),
		.arst_n    (arst_n),
		.lookup    (lookup),
		.ip        (ip),
		.tags      (set_tags),
		.lines     (set_lines),
		.valid     (set_valid),
		.hit_valid (hit_valid),
		.hit       (hit),
		.hit_way   (hit_way),
		.hit_data  (hit_data)
	);

	icache_fill_ctrl u_fill_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.fill        (fill),
		.fill_addr   (fill_addr),
		.inv         (inv),
		.lookup      (lookup),
		.lookup_ip   (ip),
		.old_tags    (set_tags),
		.rd_index    (tag_rd_index),
		.valid       (set_valid),
		.wr_mask     (wr_mask),
		.wr_index    (wr_index),
		.wr_tag      (wr_tag),
		.evict_valid (evict_valid),
		.evict_tag   (evict_tag)
	);

endmodule

/* icache/icache_way_array.sv */
/*
 * Cache way array
 * Keeps one entry per way and set, writes the masked ways at one index
 * and returns every way of one set without a clock
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_way_array #(
	parameter type entry_t = logic
) (
	input  logic                 clk,
	input  icache_pkg::index_t   rd_index,
	input  icache_pkg::way_mask_t wr_mask,
	input  icache_pkg::index_t   wr_index,
	input  entry_t               wr_entry,
	output entry_t               rd_entries [`ICACHE_WAYS]
);

	// Storage is split by way so each way can be its own RAM
	entry_t mem [`ICACHE_WAYS][`ICACHE_LINES];

	// =========================================================================
	// Write port
	// =========================================================================

	// The same entry goes to every way that the mask selects
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
		begin
			if (wr_mask[w])
				mem[w][wr_index] <= wr_entry;
		end
	end

	// =========================================================================
	// Read port
	// =========================================================================

	// All ways of the addressed set come out together for tag compare
	always_comb
	begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
			rd_entries[w] = mem[w][rd_index];
	end

	// The fill controller must pick a single victim way per fill
	// Two written ways would leave a duplicate line in the set
	a_wr_mask_onehot: assert property (
		@(posedge clk) !$isunknown(wr_mask) |-> $onehot0(wr_mask)
	);

endmodule

/* tests/tb_icache.sv */
/*
 * Instruction cache testbench
 * Drives lookups, fills and invalidates against a reference model of
 * valid bits, tags, lines and round-robin pointers
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module tb_icache;

	import icache_pkg::*;

	logic clk;
	logic arst_n;
	logic lookup;
	logic fill;
	logic inv;
	logic [`ICACHE_AWID-1:0] ip;
	logic [`ICACHE_AWID-1:0] fill_addr;
	line_t fill_data;
	logic hit_valid;
	logic hit;
	way_t hit_way;
	line_t hit_data;
	logic evict_valid;
	tag_t evict_tag;

	// Reference state, indexed [way][set] like the arrays
	tag_t m_tag [`ICACHE_WAYS][`ICACHE_LINES];
	line_t m_data [`ICACHE_WAYS][`ICACHE_LINES];
	way_mask_t m_valid [`ICACHE_LINES];
	way_t m_rr [`ICACHE_LINES];

	// Expected outputs, registered at the same edge as the DUT's
	logic exp_hit_valid;
	logic exp_hit;
	logic exp_evict_valid;
	logic data_known;
	way_t exp_way;
	line_t exp_data;
	tag_t exp_evict_tag;
	integer seed = 32'h39dc42f1;

	icache_top DUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.lookup      (lookup),
		.ip          (ip),
		.fill        (fill),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.inv         (inv),
		.hit_valid   (hit_valid),
		.hit         (hit),
		.hit_way     (hit_way),
		.hit_data    (hit_data),
		.evict_valid (evict_valid),
		.evict_tag   (evict_tag)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Random byte offset, the tag and set are what matter for a lookup
	function automatic logic [31:0] set_addr(input logic [18:0] hi, input index_t s);
		return {hi, s, 6'($random(seed))};
	endfunction

	// True when the model holds a valid line for this address
	function automatic logic line_present(input logic [31:0] a);
		index_t s;
		logic found;
		s = a[`ICACHE_OFFSET_W +: INDEX_W];
		found = 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++)
		begin
			if (m_valid[s][w] && m_tag[w][s] == a[`ICACHE_AWID-1:`ICACHE_OFFSET_W])
				found = 1'b1;
		end
		return found;
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================

	always @(posedge clk or negedge arst_n)
	begin : model
		index_t s;
		way_t v;
		logic hit_now;
		if (!arst_n)
		begin
			for (int i = 0; i < `ICACHE_LINES; i++)
			begin
				m_valid[i] = '0;
				m_rr[i] = '0;
			end
			exp_hit_valid <= 1'b0;
			exp_hit <= 1'b0;
			exp_evict_valid <= 1'b0;
			exp_way <= '0;
			data_known <= 1'b0;
		end
		else
		begin
			exp_hit_valid <= lookup;
			exp_hit <= 1'b0;
			if (lookup)
			begin
				s = ip[`ICACHE_OFFSET_W +: INDEX_W];
				hit_now = 1'b0;
				// A way hits when it is valid and holds every address bit above the offset
				for (int w = 0; w < `ICACHE_WAYS; w++)
				begin
					if (m_valid[s][w] && m_tag[w][s] == ip[`ICACHE_AWID-1:`ICACHE_OFFSET_W])
					begin
						hit_now = 1'b1;
						exp_way <= way_t'(w);
						exp_data <= m_data[w][s];
					end
				end
				exp_hit <= hit_now;
				if (hit_now)
					data_known <= 1'b1;
			end
			// The victim is the set's pointed way, reported only if it held a line
			s = fill_addr[`ICACHE_OFFSET_W +: INDEX_W];
			v = m_rr[s];
			exp_evict_valid <= fill && !inv && m_valid[s][v];
			if (fill && !inv && m_valid[s][v])
				exp_evict_tag <= m_tag[v][s];
			// Invalidate wins over a fill and leaves the pointers alone
			if (inv)
			begin
				for (int i = 0; i < `ICACHE_LINES; i++)
					m_valid[i] = '0;
			end
			else if (fill)
			begin
				m_tag[v][s] = fill_addr[`ICACHE_AWID-1:`ICACHE_OFFSET_W];
				m_data[v][s] = fill_data;
				m_valid[s][v] = 1'b1;
				m_rr[s] = v + way_t'(1);
			end
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	a_hit_valid: assert property (@(posedge clk) disable iff (!arst_n)
		hit_valid == exp_hit_valid)
		else fail_run($sformatf("MISMATCH hit_valid: got %h expected %h",
			hit_valid, exp_hit_valid));
	a_hit: assert property (@(posedge clk) disable iff (!arst_n)
		hit_valid |-> hit == exp_hit)
		else fail_run($sformatf("MISMATCH hit: got %h expected %h", hit, exp_hit));
	// On a miss the way and line of the last hit stay
	a_hit_way: assert property (@(posedge clk) disable iff (!arst_n)
		hit_valid |-> hit_way == exp_way)
		else fail_run($sformatf("MISMATCH hit_way: got %h expected %h", hit_way, exp_way));
	a_hit_data: assert property (@(posedge clk) disable iff (!arst_n)
		hit_valid && data_known |-> hit_data == exp_data)
		else fail_run($sformatf("MISMATCH hit_data: got %h expected %h",
			hit_data, exp_data));
	a_evict_valid: assert property (@(posedge clk) disable iff (!arst_n)
		evict_valid == exp_evict_valid)
		else fail_run($sformatf("MISMATCH evict_valid: got %h expected %h",
			evict_valid, exp_evict_valid));
	a_evict_tag: assert property (@(posedge clk) disable iff (!arst_n)
		evict_valid |-> evict_tag == exp_evict_tag)
		else fail_run($sformatf("MISMATCH evict_tag: got %h expected %h",
			evict_tag, exp_evict_tag));

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic probe_addr(input logic [31:0] a);
		int n;
		@(posedge clk);
		lookup <= 1'b1;
		ip <= a;
		@(posedge clk);
		lookup <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > 20)
				fail_run("Timeout waiting for hit_valid after a lookup");
		end while (!hit_valid);
	endtask

	task automatic fill_line(input logic [31:0] a);
		@(posedge clk);
		fill <= 1'b1;
		fill_addr <= a;
		fill_data <= {$random(seed), $random(seed), $random(seed), $random(seed)};
		@(posedge clk);
		fill <= 1'b0;
	endtask

	initial
	begin : stimulus
		logic [31:0] a;
		int r;
		int n;
		arst_n <= 1'b0;
		lookup <= 1'b0;
		fill <= 1'b0;
		inv <= 1'b0;
		ip <= '0;
		fill_addr <= '0;
		fill_data <= '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		// Cold cache, everything misses
		repeat (8) probe_addr($random(seed));
		// Four tags fill ways 0 to 3 of one set, then all hit
		for (int k = 1; k <= 4; k++)
			fill_line(set_addr(19'(k), 7'h2a));
		for (int k = 1; k <= 4; k++)
			probe_addr(set_addr(19'(k), 7'h2a));
		// A fifth tag displaces way 0, the first lookup then misses after a hit
		fill_line(set_addr(19'd5, 7'h2a));
		for (int k = 1; k <= 5; k++)
			probe_addr(set_addr(19'(k), 7'h2a));
		@(posedge clk);
		inv <= 1'b1;
		@(posedge clk);
		inv <= 1'b0;
		for (int k = 1; k <= 5; k++)
			probe_addr(set_addr(19'(k), 7'h2a));
		// Pointer sits at way 1 and that way is now empty
		fill_line(set_addr(19'd6, 7'h2a));
		probe_addr(set_addr(19'd6, 7'h2a));
		// Random traffic over four sets and eight tags, fill and lookup never meet
		for (int c = 0; c < 400; c++)
		begin
			@(negedge clk);
			r = {$random(seed)} % 64;
			a = set_addr(19'({$random(seed)} % 8), 7'({$random(seed)} % 4));
			// Only a missing line is fetched, so a set never holds one tag twice
			// The fill still on the pins is not in the model yet
			if (r >= 2 && r < 24 && (line_present(a) ||
				(fill && fill_addr[`ICACHE_AWID-1:`ICACHE_OFFSET_W] ==
				a[`ICACHE_AWID-1:`ICACHE_OFFSET_W])))
				r = 24;
			@(posedge clk);
			inv <= (r < 2);
			fill <= (r == 0) || (r >= 2 && r < 24);
			lookup <= (r >= 24);
			ip <= a;
			fill_addr <= a;
			fill_data <= {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
		@(posedge clk);
		lookup <= 1'b0;
		fill <= 1'b0;
		inv <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > 20)
				fail_run("Timeout waiting for the last results to drain");
		end while (hit_valid || evict_valid);
		$display("TEST OK");
		$finish;
	end

endmodule
